/* list.f */
+incdir+verilog
verilog/eu_pkg.sv
verilog/sdram_read_mux.sv
verilog/eu_fetch_engine.sv
verilog/stmm_wrapper.sv
verilog/layernorm_wrapper.sv
verilog/lut_wrapper.sv
verilog/eu_top.sv
sim/sdram_model.sv
sim/tb_eu_top.sv

/* sim/tb_eu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module tb_eu_top
    import eu_pkg::*;
();

localparam int NUM_ROWS   = 7;
localparam int WAIT_LIMIT = 150;

logic           clk;
logic           i_rst;
logic [31:0]    o_sdram_address;
logic           o_sdram_read;
logic [63:0]    i_sdram_readdata;
logic           i_sdram_readdatavalid;
logic           i_sdram_waitrequest;
logic [4:0]     i_sdram_read_sel;
logic [31:0]    i_eu_fetch;
logic [31:0]    i_eu_exec;
logic [31:0]    i_eu_fetch_addr;
logic           o_stmm_rmio_wr;
logic [1:0]     o_stmm_rmio_addr;
logic [15:0]    o_stmm_rmio_wdata;
logic           o_layernorm_rmio_wr;
logic           o_layernorm_rmio_addr;
logic [15:0]    o_layernorm_rmio_wdata;
logic           o_lut_rmio_wr;
logic           o_lut_rmio_addr;
logic [15:0]    o_lut_rmio_wdata;
logic           o_fetch_done;
logic [27:0]    o_exec_done;

// Stimulus table of fetch group, fetch address, exec group and exec mask
int          tbl_fetch_grp [NUM_ROWS] = '{0, 1, 2, 2, 0, 1, 0};
logic [31:0] tbl_addr      [NUM_ROWS] = '{32'h10, 32'h25, 32'h40, 32'h7a,
                                          32'h1234, 32'h3c0, 32'h99};
int          tbl_exec_grp  [NUM_ROWS] = '{0, 1, 2, 0, 2, 0, 1};
logic [3:0]  tbl_mask      [NUM_ROWS] = '{4'hf, 4'h1, 4'h3, 4'h5, 4'h2, 4'h6, 4'h1};

logic [31:0]    last_addr [3];
logic [31:0]    rd_addr_exp;
int             rd_accepted;
int             cyc;
int             read_cycles;
int             check_count;
int             error_count;
int             wr_grp [$];
logic [1:0]     wr_idx [$];
eu_lane_t       wr_data [$];
int             wr_cyc [$];
logic [1:0]     exp_idx [$];
eu_lane_t       exp_data [$];

eu_top UUT (.*);

sdram_model u_sdram (
    .clk             (clk),
    .i_address       (o_sdram_address),
    .i_read          (o_sdram_read),
    .o_readdata      (i_sdram_readdata),
    .o_readdatavalid (i_sdram_readdatavalid),
    .o_waitrequest   (i_sdram_waitrequest)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) cyc <= cyc + 1;

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////
task automatic check_lane(input eu_lane_t got, input eu_lane_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_done(input logic [27:0] got, input logic [27:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_index(input logic [1:0] got, input logic [1:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_addr(input logic [`EU_ADDR_W-1:0] got, input logic [`EU_ADDR_W-1:0] exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////
function automatic eu_lane_t lane_value(input logic [31:0] addr, input int l);
    logic [15:0] v;
    v = addr[15:0] * 16'h0137 + 16'(l) * 16'h0011;
    return eu_lane_t'(v & 16'h0fff);
endfunction

task automatic build_expected(input int grp, input logic [3:0] mask, input logic [31:0] a);
    logic [31:0] p;
    int          sum;
    int          idx;
    exp_idx.delete();
    exp_data.delete();
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
            exp_idx.push_back(2'(i));
            case (grp)
                // Low half of the lane product
                0: begin
                    p = lane_value(a, i) * lane_value(a + 1, i);
                    exp_data.push_back(eu_lane_t'(p[15:0]));
                end
                // Lane 0 minus the mean of word 0
                1: begin
                    sum = 0;
                    for (int l = 0; l < `EU_LANES; l++) begin
                        sum += lane_value(a, l);
                    end
                    exp_data.push_back(eu_lane_t'(lane_value(a, 0) - (sum >>> 2)));
                end
                default: begin
                    idx = lane_value(a + 1, i) & 3;
                    exp_data.push_back(lane_value(a, idx));
                end
            endcase
        end
    end
endtask

function automatic logic [31:0] group_vector(input int grp, input logic [3:0] mask);
    return (grp == 0) ? {28'd0, mask} : (grp == 1) ? {27'd0, mask[0], 4'd0}
                                                   : {22'd0, mask[1:0], 8'd0};
endfunction

// Sample RMIO writes, bus reads and padding bits mid-cycle
always @(negedge clk) begin
    if (!i_rst) begin
        if (o_stmm_rmio_wr) begin
            wr_grp.push_back(0);
            wr_idx.push_back(o_stmm_rmio_addr);
            wr_data.push_back(o_stmm_rmio_wdata);
            wr_cyc.push_back(cyc);
        end
        if (o_layernorm_rmio_wr) begin
            wr_grp.push_back(1);
            wr_idx.push_back({1'b0, o_layernorm_rmio_addr});
            wr_data.push_back(o_layernorm_rmio_wdata);
            wr_cyc.push_back(cyc);
        end
        if (o_lut_rmio_wr) begin
            wr_grp.push_back(2);
            wr_idx.push_back({1'b0, o_lut_rmio_addr});
            wr_data.push_back(o_lut_rmio_wdata);
            wr_cyc.push_back(cyc);
        end
        if (o_sdram_read) begin
            read_cycles++;
            // Accepted reads walk up from the fetch address
            if (!i_sdram_waitrequest) begin
                check_addr(o_sdram_address, rd_addr_exp, "SDRAM read address");
                rd_addr_exp = rd_addr_exp + 1;
                rd_accepted++;
            end
        end
        if (o_exec_done[27:10] !== 18'h3ffff || o_exec_done[7:5] !== 3'b111) begin
            error_count++;
            $display("CHECK FAILED at %0t: exec_done padding bits read %h", $time, o_exec_done);
        end
    end
end

////////////////////////////////////////////////////////////////////////////
// Row sequence
////////////////////////////////////////////////////////////////////////////
task automatic run_fetch(input int grp, input logic [31:0] a, input int row);
    int n;
    rd_addr_exp = a;
    rd_accepted = 0;
    @(posedge clk);
    i_sdram_read_sel <= {3'(grp), 2'(row)};
    i_eu_fetch       <= group_vector(grp, 4'h1);
    i_eu_fetch_addr  <= a;
    @(posedge clk);
    i_eu_fetch <= '0;
    @(negedge clk);
    check_flag(o_fetch_done, 1'b0, "fetch_done after fetch pulse");
    n = 0;
    while (!o_fetch_done && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (!o_fetch_done) begin
        error_count++;
        $display("Fetch of group %0d from %h never completed", grp, a);
    end
    check_count++;
    if (rd_accepted != `EU_FETCH_WORDS) begin
        error_count++;
        $display("CHECK FAILED at %0t: fetch made %0d reads expected %0d",
                 $time, rd_accepted, `EU_FETCH_WORDS);
    end
    last_addr[grp] = a;
endtask

task automatic run_exec(input int grp, input logic [3:0] mask);
    logic [31:0] vec;
    int          ref_cyc;
    int          n;
    vec = group_vector(grp, mask);
    build_expected(grp, mask, last_addr[grp]);
    wr_grp.delete();
    wr_idx.delete();
    wr_data.delete();
    wr_cyc.delete();
    @(posedge clk);
    i_eu_exec <= vec;
    @(posedge clk);
    i_eu_exec <= '0;
    @(negedge clk);
    ref_cyc = cyc;
    // Only the addressed bits drop
    check_done(o_exec_done, ~vec[27:0], "exec_done after exec pulse");
    n = 0;
    while (o_exec_done !== 28'hfffffff && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (o_exec_done !== 28'hfffffff) begin
        error_count++;
        $display("exec_done of group %0d never returned high", grp);
    end
    for (int k = 0; k < exp_idx.size(); k++) begin
        if (k >= wr_idx.size()) begin
            error_count++;
            $display("Missing RMIO write from group %0d sub-unit %0d", grp, exp_idx[k]);
        end else begin
            check_index(2'(wr_grp[k]), 2'(grp), "RMIO port");
            check_index(wr_idx[k], exp_idx[k], "RMIO address");
            check_lane(wr_data[k], exp_data[k], "RMIO data");
            // First write 2 cycles after the pulse, then one per cycle
            check_count++;
            if (wr_cyc[k] != ref_cyc + 1 + k) begin
                error_count++;
                $display("CHECK FAILED at %0t: write %0d in cycle %0d expected %0d",
                         $time, k, wr_cyc[k], ref_cyc + 1 + k);
            end
        end
    end
    if (wr_idx.size() > exp_idx.size()) begin
        error_count++;
        $display("Group %0d made %0d RMIO writes where %0d were expected",
                 grp, wr_idx.size(), exp_idx.size());
    end
endtask

initial begin
    i_rst            = 1'b1;
    i_sdram_read_sel = '0;
    i_eu_fetch       = '0;
    i_eu_exec        = '0;
    i_eu_fetch_addr  = '0;
    cyc              = 0;
    read_cycles      = 0;
    check_count      = 0;
    error_count      = 0;
    rd_addr_exp      = '0;
    rd_accepted      = 0;
    last_addr        = '{32'd0, 32'd0, 32'd0};
    repeat (10) @(posedge clk);
    i_rst <= 1'b0;

    // Idle state after reset
    repeat (4) @(negedge clk);
    check_flag(o_fetch_done, 1'b1, "fetch_done after reset");
    check_done(o_exec_done, 28'hfffffff, "exec_done after reset");
    if (read_cycles != 0 || wr_idx.size() != 0) begin
        error_count++;
        $display("Bus read or RMIO write seen while idle after reset");
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
        run_fetch(tbl_fetch_grp[r], tbl_addr[r], r);
        run_exec(tbl_exec_grp[r], tbl_mask[r]);
    end

    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

// Watchdog sized from the table length
initial begin
    repeat (NUM_ROWS * 200 + 20) @(posedge clk);
    $display("Watchdog expired before the test sequence finished");
    $display("TESTBENCH FAILED");
    $finish;
end

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module sdram_model (
    input  wire                         clk,
    input  logic [`EU_ADDR_W-1:0]       i_address,
    input  logic                        i_read,
    output logic [`EU_SDRAM_W-1:0]      o_readdata,
    output logic                        o_readdatavalid,
    output logic                        o_waitrequest
);

localparam int unsigned SEED = 32'h33d8_aeb3;

logic                   pipe_vld;
logic [`EU_ADDR_W-1:0]  pipe_addr;

// Data of one word, a fixed hash of its address
function automatic logic [`EU_SDRAM_W-1:0] word_at(input logic [`EU_ADDR_W-1:0] addr);
    logic [`EU_SDRAM_W-1:0] w;
    logic [15:0]            lane;
    w = '0;
    for (int l = 0; l < `EU_LANES; l++) begin
        lane = addr[15:0] * 16'h0137 + 16'(l) * 16'h0011;
        // Top bits cleared to keep lanes small and positive
        w[16*l +: 16] = lane & 16'h0fff;
    end
    return w;
endfunction

// Random stall, read accepted when not stalled, data 2 cycles later
initial begin
    void'($urandom(SEED));
    o_waitrequest   = 1'b1;
    o_readdatavalid = 1'b0;
    o_readdata      = '0;
    pipe_vld        = 1'b0;
    pipe_addr       = '0;
    forever begin
        @(posedge clk);
        o_readdatavalid <= pipe_vld;
        o_readdata      <= pipe_vld ? word_at(pipe_addr) : '0;
        pipe_vld        <= i_read && !o_waitrequest;
        pipe_addr       <= i_address;
        o_waitrequest   <= 1'($urandom % 2);
    end
end

endmodule

`default_nettype wire

/* verilog/eu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module eu_top (
    input  wire                             clk,
    input  logic                            i_rst,

    // Avalon-MM read master
    output logic [`EU_ADDR_W-1:0]           o_sdram_address,
    output logic                            o_sdram_read,
    input  logic [`EU_SDRAM_W-1:0]          i_sdram_readdata,
    input  logic                            i_sdram_readdatavalid,
    input  logic                            i_sdram_waitrequest,

    // Control unit
    input  logic [4:0]                      i_sdram_read_sel,
    input  logic [31:0]                     i_eu_fetch,
    input  logic [31:0]                     i_eu_exec,
    input  logic [31:0]                     i_eu_fetch_addr,

    // RMIO write ports
    output logic                            o_stmm_rmio_wr,
    output logic [1:0]                      o_stmm_rmio_addr,
    output logic [15:0]                     o_stmm_rmio_wdata,
    output logic                            o_layernorm_rmio_wr,
    output logic                            o_layernorm_rmio_addr,
    output logic [15:0]                     o_layernorm_rmio_wdata,
    output logic                            o_lut_rmio_wr,
    output logic                            o_lut_rmio_addr,
    output logic [15:0]                     o_lut_rmio_wdata,

    output logic                            o_fetch_done,
    output logic [27:0]                     o_exec_done
);

logic [1:0]                         grp_sel;
logic [2:0][`EU_ADDR_W-1:0]         grp_address;
logic [2:0]                         grp_read;
logic [2:0][`EU_SDRAM_W-1:0]        grp_readdata;
logic [2:0]                         grp_readdatavalid;
logic [2:0]                         grp_waitrequest;
logic                               stmm_fetch_done;
logic                               ln_fetch_done;
logic                               lut_fetch_done;
logic [`EU_STMM_SUBS-1:0]           stmm_exec_done;
logic [`EU_LN_SUBS-1:0]             ln_exec_done;
logic [`EU_LUT_SUBS-1:0]            lut_exec_done;

////////////////////////////////////////////////////////////////////////////
// Read select from bits 4:2 of the control field
////////////////////////////////////////////////////////////////////////////
always_comb begin
    case (i_sdram_read_sel) inside
        5'b001??: grp_sel = 2'd1;
        5'b010??: grp_sel = 2'd2;
        default:  grp_sel = 2'd0;
    endcase
end

sdram_read_mux u_mux (
    .clk                   (clk),
    .i_sel                 (grp_sel),
    .i_grp_address         (grp_address),
    .i_grp_read            (grp_read),
    .o_grp_readdata        (grp_readdata),
    .o_grp_readdatavalid   (grp_readdatavalid),
    .o_grp_waitrequest     (grp_waitrequest),
    .o_sdram_address       (o_sdram_address),
    .o_sdram_read          (o_sdram_read),
    .i_sdram_readdata      (i_sdram_readdata),
    .i_sdram_readdatavalid (i_sdram_readdatavalid),
    .i_sdram_waitrequest   (i_sdram_waitrequest)
);

////////////////////////////////////////////////////////////////////////////
// Engine groups
////////////////////////////////////////////////////////////////////////////
stmm_wrapper u_stmm (
    .clk             (clk),
    .i_rst           (i_rst),
    .o_address       (grp_address[0]),
    .o_read          (grp_read[0]),
    .i_readdata      (grp_readdata[0]),
    .i_readdatavalid (grp_readdatavalid[0]),
    .i_waitrequest   (grp_waitrequest[0]),
    .i_fetch         (i_eu_fetch[0 +: `EU_STMM_SUBS]),
    .i_exec          (i_eu_exec[0 +: `EU_STMM_SUBS]),
    .i_fetch_addr    (i_eu_fetch_addr),
    .o_rmio_wr       (o_stmm_rmio_wr),
    .o_rmio_addr     (o_stmm_rmio_addr),
    .o_rmio_wdata    (o_stmm_rmio_wdata),
    .o_fetch_done    (stmm_fetch_done),
    .o_exec_done     (stmm_exec_done)
);

layernorm_wrapper u_layernorm (
    .clk             (clk),
    .i_rst           (i_rst),
    .o_address       (grp_address[1]),
    .o_read          (grp_read[1]),
    .i_readdata      (grp_readdata[1]),
    .i_readdatavalid (grp_readdatavalid[1]),
    .i_waitrequest   (grp_waitrequest[1]),
    .i_fetch         (i_eu_fetch[4 +: `EU_LN_SUBS]),
    .i_exec          (i_eu_exec[4 +: `EU_LN_SUBS]),
    .i_fetch_addr    (i_eu_fetch_addr),
    .o_rmio_wr       (o_layernorm_rmio_wr),
    .o_rmio_addr     (o_layernorm_rmio_addr),
    .o_rmio_wdata    (o_layernorm_rmio_wdata),
    .o_fetch_done    (ln_fetch_done),
    .o_exec_done     (ln_exec_done)
);

lut_wrapper u_lut (
    .clk             (clk),
    .i_rst           (i_rst),
    .o_address       (grp_address[2]),
    .o_read          (grp_read[2]),
    .i_readdata      (grp_readdata[2]),
    .i_readdatavalid (grp_readdatavalid[2]),
    .i_waitrequest   (grp_waitrequest[2]),
    .i_fetch         (i_eu_fetch[8 +: `EU_LUT_SUBS]),
    .i_exec          (i_eu_exec[8 +: `EU_LUT_SUBS]),
    .i_fetch_addr    (i_eu_fetch_addr),
    .o_rmio_wr       (o_lut_rmio_wr),
    .o_rmio_addr     (o_lut_rmio_addr),
    .o_rmio_wdata    (o_lut_rmio_wdata),
    .o_fetch_done    (lut_fetch_done),
    .o_exec_done     (lut_exec_done)
);

// Unused positions read as one
assign o_fetch_done = stmm_fetch_done & ln_fetch_done & lut_fetch_done;
assign o_exec_done  = {16'hffff, 2'b11, lut_exec_done, 3'b111, ln_exec_done, stmm_exec_done};

endmodule

`default_nettype wire

/* verilog/lut_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module lut_wrapper
    import eu_pkg::*;
(
    input  wire                                 clk,
    input  logic                                i_rst,

    output logic [`EU_ADDR_W-1:0]               o_address,
    output logic                                o_read,
    input  logic [`EU_SDRAM_W-1:0]              i_readdata,
    input  logic                                i_readdatavalid,
    input  logic                                i_waitrequest,

    input  logic [`EU_LUT_SUBS-1:0]             i_fetch,
    input  logic [`EU_LUT_SUBS-1:0]             i_exec,
    input  logic [`EU_ADDR_W-1:0]               i_fetch_addr,

    output logic                                o_rmio_wr,
    output logic [$clog2(`EU_LUT_SUBS)-1:0]     o_rmio_addr,
    output eu_lane_t                            o_rmio_wdata,

    output logic                                o_fetch_done,
    output logic [`EU_LUT_SUBS-1:0]             o_exec_done
);

localparam int N  = `EU_LUT_SUBS;
localparam int IW = $clog2(N);
localparam int TW = $clog2(`EU_LANES);

eu_word_u [`EU_FETCH_WORDS-1:0] words;
eu_lane_t [N-1:0]               entry;
logic [N-1:0]                   pending;
logic [N-1:0]                   wr_mask;
logic [N-1:0]                   grant;
logic [IW-1:0]                  sel_idx;

eu_fetch_engine u_fetch (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_start         (|i_fetch),
    .i_addr          (i_fetch_addr),
    .o_address       (o_address),
    .o_read          (o_read),
    .i_readdata      (i_readdata),
    .i_readdatavalid (i_readdatavalid),
    .i_waitrequest   (i_waitrequest),
    .o_words         (words),
    .o_fetch_done    (o_fetch_done)
);

////////////////////////////////////////////////////////////////////////////
// Table lookup: word 1 lanes index into word 0 bits
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
        entry[i] <= words[0].raw[words[1].lane[i][TW-1:0] * 16 +: 16];
    end
end

always_comb begin
    sel_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
        if (pending[i]) begin
            sel_idx = IW'(i);
        end
    end
end

assign grant       = (|pending) ? (N'(1) << sel_idx) : '0;
assign o_exec_done = ~(pending | wr_mask);

always_ff @(posedge clk) begin
    if (i_rst) begin
        pending   <= '0;
        wr_mask   <= '0;
        o_rmio_wr <= 1'b0;
    end else begin
        pending   <= (pending & ~grant) | (i_exec & o_exec_done);
        wr_mask   <= grant;
        o_rmio_wr <= |pending;
    end
end

always_ff @(posedge clk) begin
    o_rmio_addr  <= sel_idx;
    o_rmio_wdata <= entry[sel_idx];
end

endmodule

`default_nettype wire

/* verilog/layernorm_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module layernorm_wrapper
    import eu_pkg::*;
(
    input  wire                         clk,
    input  logic                        i_rst,

    output logic [`EU_ADDR_W-1:0]       o_address,
    output logic                        o_read,
    input  logic [`EU_SDRAM_W-1:0]      i_readdata,
    input  logic                        i_readdatavalid,
    input  logic                        i_waitrequest,

    input  logic [`EU_LN_SUBS-1:0]      i_fetch,
    input  logic [`EU_LN_SUBS-1:0]      i_exec,
    input  logic [`EU_ADDR_W-1:0]       i_fetch_addr,

    output logic                        o_rmio_wr,
    output logic                        o_rmio_addr,
    output eu_lane_t                    o_rmio_wdata,

    output logic                        o_fetch_done,
    output logic [`EU_LN_SUBS-1:0]      o_exec_done
);

localparam int SH = $clog2(`EU_LANES);
localparam int SW = 16 + SH;

eu_word_u [`EU_FETCH_WORDS-1:0] words;
logic signed [SW-1:0]           sum_next;
logic signed [SW-1:0]           lane_sum;
eu_lane_t                       mean;
logic                           busy;

eu_fetch_engine u_fetch (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_start         (|i_fetch),
    .i_addr          (i_fetch_addr),
    .o_address       (o_address),
    .o_read          (o_read),
    .i_readdata      (i_readdata),
    .i_readdatavalid (i_readdatavalid),
    .i_waitrequest   (i_waitrequest),
    .o_words         (words),
    .o_fetch_done    (o_fetch_done)
);

// Sum of word 0 lanes, wide enough not to overflow
always_comb begin
    sum_next = '0;
    for (int i = 0; i < `EU_LANES; i++) begin
        sum_next = sum_next + words[0].lane[i];
    end
end

assign mean        = eu_lane_t'(lane_sum >>> SH);
assign o_rmio_addr = 1'b0;
assign o_exec_done = ~(busy | o_rmio_wr);

always_ff @(posedge clk) begin
    if (i_rst) begin
        busy      <= 1'b0;
        o_rmio_wr <= 1'b0;
    end else begin
        busy      <= i_exec[0] && o_exec_done[0];
        o_rmio_wr <= busy;
    end
end

// Stage 1 holds the sum, stage 2 the centered lane
always_ff @(posedge clk) begin
    lane_sum     <= sum_next;
    o_rmio_wdata <= words[0].lane[0] - mean;
end

endmodule

`default_nettype wire

/* verilog/stmm_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module stmm_wrapper
    import eu_pkg::*;
(
    input  wire                                 clk,
    input  logic                                i_rst,

    output logic [`EU_ADDR_W-1:0]               o_address,
    output logic                                o_read,
    input  logic [`EU_SDRAM_W-1:0]              i_readdata,
    input  logic                                i_readdatavalid,
    input  logic                                i_waitrequest,

    input  logic [`EU_STMM_SUBS-1:0]            i_fetch,
    input  logic [`EU_STMM_SUBS-1:0]            i_exec,
    input  logic [`EU_ADDR_W-1:0]               i_fetch_addr,

    output logic                                o_rmio_wr,
    output logic [$clog2(`EU_STMM_SUBS)-1:0]    o_rmio_addr,
    output eu_lane_t                            o_rmio_wdata,

    output logic                                o_fetch_done,
    output logic [`EU_STMM_SUBS-1:0]            o_exec_done
);

localparam int N  = `EU_STMM_SUBS;
localparam int IW = $clog2(N);

eu_word_u [`EU_FETCH_WORDS-1:0] words;
eu_lane_t [N-1:0]               prod;
logic [N-1:0]                   pending;
logic [N-1:0]                   wr_mask;
logic [N-1:0]                   grant;
logic [IW-1:0]                  sel_idx;

eu_fetch_engine u_fetch (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_start         (|i_fetch),
    .i_addr          (i_fetch_addr),
    .o_address       (o_address),
    .o_read          (o_read),
    .i_readdata      (i_readdata),
    .i_readdatavalid (i_readdatavalid),
    .i_waitrequest   (i_waitrequest),
    .o_words         (words),
    .o_fetch_done    (o_fetch_done)
);

// Lane products, low 16 bits kept
always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
        prod[i] <= words[0].lane[i] * words[1].lane[i];
    end
end

// Lowest pending sub-unit goes first
always_comb begin
    sel_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
        if (pending[i]) begin
            sel_idx = IW'(i);
        end
    end
end

assign grant       = (|pending) ? (N'(1) << sel_idx) : '0;
assign o_exec_done = ~(pending | wr_mask);

always_ff @(posedge clk) begin
    if (i_rst) begin
        pending   <= '0;
        wr_mask   <= '0;
        o_rmio_wr <= 1'b0;
    end else begin
        // Pulses to busy sub-units are dropped
        pending   <= (pending & ~grant) | (i_exec & o_exec_done);
        wr_mask   <= grant;
        o_rmio_wr <= |pending;
    end
end

always_ff @(posedge clk) begin
    o_rmio_addr  <= sel_idx;
    o_rmio_wdata <= prod[sel_idx];
end

endmodule

`default_nettype wire

/* verilog/eu_fetch_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module eu_fetch_engine
    import eu_pkg::*;
(
    input  wire                                 clk,
    input  logic                                i_rst,

    input  logic                                i_start,
    input  logic [`EU_ADDR_W-1:0]               i_addr,

    // Avalon-MM read, group side
    output logic [`EU_ADDR_W-1:0]               o_address,
    output logic                                o_read,
    input  logic [`EU_SDRAM_W-1:0]              i_readdata,
    input  logic                                i_readdatavalid,
    input  logic                                i_waitrequest,

    output eu_word_u [`EU_FETCH_WORDS-1:0]      o_words,
    output logic                                o_fetch_done
);

localparam int AW    = `EU_ADDR_W;
localparam int CNT_W = $clog2(`EU_FETCH_WORDS + 1);
localparam logic [CNT_W-1:0] LAST = CNT_W'(`EU_FETCH_WORDS - 1);

typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

state_t             state;
logic [AW-1:0]      base;
logic [CNT_W-1:0]   req_cnt;
logic [CNT_W-1:0]   ret_cnt;

assign o_read    = (state == ST_REQ);
assign o_address = base + AW'(req_cnt);

always_ff @(posedge clk) begin
    if (i_rst) begin
        state        <= ST_IDLE;
        base         <= '0;
        req_cnt      <= '0;
        ret_cnt      <= '0;
        o_words      <= '0;
        o_fetch_done <= 1'b1;
    end else begin
        case (state)
            ST_IDLE: if (i_start) begin
                base         <= i_addr;
                req_cnt      <= '0;
                ret_cnt      <= '0;
                o_fetch_done <= 1'b0;
                state        <= ST_REQ;
            end
            // Address phase, stalls on waitrequest
            ST_REQ: if (!i_waitrequest) begin
                req_cnt <= req_cnt + 1'b1;
                if (req_cnt == LAST) begin
                    state <= ST_WAIT;
                end
            end
            default: ;
        endcase

        // Words come back in order, may overlap the address phase
        if (i_readdatavalid && state != ST_IDLE) begin
            o_words[ret_cnt].raw <= i_readdata;
            ret_cnt              <= ret_cnt + 1'b1;
            if (ret_cnt == LAST) begin
                state        <= ST_IDLE;
                o_fetch_done <= 1'b1;
            end
        end
    end
end

a_addr_hold: assert property (@(posedge clk) disable iff (i_rst)
    (o_read && i_waitrequest) |=> (o_read && $stable(o_address)));

a_no_stray_data: assert property (@(posedge clk) disable iff (i_rst)
    i_readdatavalid |-> (state != ST_IDLE));

endmodule

`default_nettype wire

/* verilog/sdram_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none
`include "eu_cfg.svh"

module sdram_read_mux #(
    parameter int NUM_PORTS = 3
) (
    input  wire                                     clk,
    input  logic [1:0]                              i_sel,

    // Group side
    input  logic [NUM_PORTS-1:0][`EU_ADDR_W-1:0]    i_grp_address,
    input  logic [NUM_PORTS-1:0]                    i_grp_read,
    output logic [NUM_PORTS-1:0][`EU_SDRAM_W-1:0]   o_grp_readdata,
    output logic [NUM_PORTS-1:0]                    o_grp_readdatavalid,
    output logic [NUM_PORTS-1:0]                    o_grp_waitrequest,

    // Avalon-MM master side
    output logic [`EU_ADDR_W-1:0]                   o_sdram_address,
    output logic                                    o_sdram_read,
    input  logic [`EU_SDRAM_W-1:0]                  i_sdram_readdata,
    input  logic                                    i_sdram_readdatavalid,
    input  logic                                    i_sdram_waitrequest
);

always_comb begin
    o_sdram_address = '0;
    o_sdram_read    = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
        // Data goes to every port, only valid is steered
        o_grp_readdata[p]      = i_sdram_readdata;
        o_grp_readdatavalid[p] = i_sdram_readdatavalid && (i_sel == p);
        // Unselected ports look permanently stalled
        o_grp_waitrequest[p]   = i_sdram_waitrequest || (i_sel != p);
        if (i_sel == p) begin
            o_sdram_address = i_grp_address[p];
            o_sdram_read    = i_grp_read[p];
        end
    end
end

// No group may request while the select points nowhere
a_sel_in_range: assert property (@(posedge clk) (i_sel >= NUM_PORTS) |-> !(|i_grp_read));

endmodule

`default_nettype wire

/* verilog/eu_pkg.sv */
`include "eu_cfg.svh"

package eu_pkg;

// One signed lane
typedef logic signed [15:0] eu_lane_t;

////////////////////////////////////////////////////////////////////////////
// SDRAM word, taken either as raw bits or as lanes
////////////////////////////////////////////////////////////////////////////
typedef union packed {
    logic [`EU_SDRAM_W-1:0]     raw;
    eu_lane_t [`EU_LANES-1:0]   lane;
} eu_word_u;

endpackage

/* verilog/eu_cfg.svh */
`ifndef EU_CFG_SVH
`define EU_CFG_SVH

// SDRAM side
`define EU_SDRAM_W      64
`define EU_ADDR_W       32

// Lanes of 16 bits in one SDRAM word
`define EU_LANES        4

// Words read per fetch
`define EU_FETCH_WORDS  2

// Sub-units per engine group
`define EU_STMM_SUBS    4
`define EU_LN_SUBS      1
`define EU_LUT_SUBS     2

`endif
